// ==== build.f ====
+incdir+.
cpu_pkg.sv
controller.sv
instruction_fetch.sv
datapath.sv
data_memory.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_cpu
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_cpu.sv ====
// testbench of the load/store core; loads programs over the host port and checks memory and timing
`include "cpu_settings.svh"

module tb_cpu
  import cpu_pkg::*;
();

  logic       clk = 1'b0;
  logic       rst;
  logic       run;
  logic       host_imem_we;
  logic       host_dmem_we;
  dmem_addr_t host_addr;
  word_t      host_wdata;
  word_t      host_rdata;
  logic       halted;

  word_t       m_reg [`CPU_REG_COUNT];   // model register file
  word_t       m_mem [`CPU_DMEM_DEPTH];  // model data memory
  word_t       prog [$];
  logic [31:0] seed = 32'h5f7a_797a;
  int          cycles;
  int          budget = 200;  // loading margin, grows per test
  int          errors = 0;
  int          checks = 0;

  cpu_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .host_imem_we (host_imem_we),
    .host_dmem_we (host_dmem_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .host_rdata   (host_rdata),
    .halted       (halted)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  // run-to-halt cycle counter
  always @(posedge clk)
  begin
    if (rst || !run)
      cycles <= 0;
    else if (!halted)
      cycles <= cycles + 1;
  end

  function automatic word_t rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];  // upper bits, better period
  endfunction

  function automatic word_t mem_op(opcode_t op, dmem_addr_t a, reg_addr_t r);
    return {op, a, r};
  endfunction

  function automatic word_t alu_op(opcode_t op, reg_addr_t ra, reg_addr_t rb, reg_addr_t rd);
    return {op, ra, rb, rd};
  endfunction

  // executes prog on the model, returns cycles from run high to halted
  function automatic int ref_run();
    int    pc;
    int    count;
    word_t ins;
    pc = 0;
    count = 1;  // S_INIT
    while (pc < prog.size())
    begin
      ins = prog[pc];
      case (ins[15:12])
        OP_STORE: m_mem[ins[11:4]] = m_reg[ins[3:0]];
        OP_LOAD:  m_reg[ins[3:0]] = m_mem[ins[11:4]];
        OP_ADD:   m_reg[ins[3:0]] = m_reg[ins[11:8]] + m_reg[ins[7:4]];
        OP_SUB:   m_reg[ins[3:0]] = m_reg[ins[11:8]] - m_reg[ins[7:4]];
        OP_HALT:  return count + 2;  // fetch and decode of the halt
        default:  ;  // noop and unknown codes change nothing
      endcase
      count = count + ((ins[15:12] == OP_LOAD) ? 4 : 3);
      pc++;
    end
    return count;
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Error in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_cycles(string name, int exp, int act);
    checks++;
    if (exp != act)
    begin
      errors++;
      $display("Error in %s: expected %0d cycles, actual %0d cycles", name, exp, act);
    end
  endtask

  task automatic check_halted(string name, logic exp, logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Error in %s: expected halted %b, actual %b", name, exp, act);
    end
  endtask

  task automatic host_write(logic to_imem, dmem_addr_t addr, word_t data);
    host_imem_we = to_imem;
    host_dmem_we = !to_imem;
    host_addr    = addr;
    host_wdata   = data;
    @(negedge clk);
    host_imem_we = 1'b0;
    host_dmem_we = 1'b0;
  endtask

  task automatic poke(dmem_addr_t addr, word_t data);
    host_write(1'b0, addr, data);
    m_mem[addr] = data;
  endtask

  task automatic load_program();
    run = 1'b0;  // host writes only while stopped
    budget += prog.size() + 20;
    for (int i = 0; i < prog.size(); i++)
      host_write(1'b1, dmem_addr_t'(i), prog[i]);
  endtask

  task automatic compare_memory(string name);
    for (int a = 0; a < `CPU_DMEM_DEPTH; a++)
    begin
      host_addr = dmem_addr_t'(a);
      @(negedge clk);  // one cycle read latency
      check_word($sformatf("%s mem[%0d]", name, a), m_mem[a], host_rdata);
    end
  endtask

  task automatic run_and_check(string name);
    int exp_cycles;
    exp_cycles = ref_run();
    budget += exp_cycles + `CPU_DMEM_DEPTH + 20;
    check_halted({name, " stopped"}, 1'b0, halted);  // run low means S_INIT
    run = 1'b1;
    while (!halted)
      @(negedge clk);
    check_cycles(name, exp_cycles, cycles);
    compare_memory(name);
  endtask

  task automatic report_and_finish(bit timed_out);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  initial
  begin : watchdog
    int cyc;
    cyc = 0;
    while (cyc < budget)
    begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout after %0d cycles, the core never halted", cyc);
    report_and_finish(1'b1);
  end

  initial
  begin : stimulus
    reg_addr_t r;
    word_t     w;
    rst = 1'b1;
    run = 1'b0;
    host_imem_we = 1'b0;
    host_dmem_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    for (int i = 0; i < `CPU_REG_COUNT; i++)
      m_reg[i] = '0;  // register file clears on reset
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // idle state and host port
    check_halted("idle", 1'b0, halted);
    budget += `CPU_DMEM_DEPTH + 20;
    for (int a = 0; a < `CPU_DMEM_DEPTH; a++)
      poke(dmem_addr_t'(a), rand_word());
    poke(8'h5a, 16'hc0de);
    @(negedge clk);
    check_word("host_readback", 16'hc0de, host_rdata);

    // load then store
    for (int i = 0; i < 8; i++)
    begin
      r = reg_addr_t'(rand_word());
      prog.push_back(mem_op(OP_LOAD, dmem_addr_t'(rand_word()), r));
      prog.push_back(mem_op(OP_STORE, dmem_addr_t'(rand_word()), r));
    end
    prog.push_back(16'h5000);
    load_program();
    run_and_check("load_store");

    // add and sub with forced wraps, then random operands
    prog.delete();
    prog.push_back(mem_op(OP_LOAD, 8'd0, 4'd1));
    prog.push_back(mem_op(OP_LOAD, 8'd1, 4'd2));
    prog.push_back(mem_op(OP_LOAD, 8'd2, 4'd5));
    prog.push_back(alu_op(OP_ADD, 4'd1, 4'd2, 4'd3));  // ffff + 1
    prog.push_back(alu_op(OP_SUB, 4'd2, 4'd1, 4'd4));  // 1 - ffff
    prog.push_back(alu_op(OP_ADD, 4'd5, 4'd5, 4'd6));  // 8000 + 8000
    prog.push_back(mem_op(OP_STORE, 8'd16, 4'd3));
    prog.push_back(mem_op(OP_STORE, 8'd17, 4'd4));
    prog.push_back(mem_op(OP_STORE, 8'd18, 4'd6));
    for (int i = 0; i < 6; i++)
    begin
      r = reg_addr_t'(rand_word());
      w = rand_word();
      prog.push_back(mem_op(OP_LOAD, dmem_addr_t'(rand_word()), r));
      prog.push_back(alu_op(w[0] ? OP_SUB : OP_ADD, r, reg_addr_t'(rand_word()), r));
      prog.push_back(mem_op(OP_STORE, dmem_addr_t'(rand_word()), r));
    end
    prog.push_back(16'h5000);
    load_program();
    poke(8'd0, 16'hffff);
    poke(8'd1, 16'h0001);
    poke(8'd2, 16'h8000);
    run_and_check("add_sub");

    // noops and unknown opcodes
    prog.delete();
    prog.push_back(16'h0000);
    prog.push_back(mem_op(OP_LOAD, 8'd40, 4'd7));
    prog.push_back(16'h9123);  // unknown
    prog.push_back(alu_op(OP_ADD, 4'd7, 4'd3, 4'd8));
    prog.push_back(16'hf0ff);  // unknown
    prog.push_back(mem_op(OP_STORE, 8'd41, 4'd8));
    prog.push_back(16'h0abc);
    prog.push_back(alu_op(OP_SUB, 4'd8, 4'd7, 4'd9));
    prog.push_back(16'h6321);  // unknown
    prog.push_back(mem_op(OP_STORE, 8'd42, 4'd9));
    prog.push_back(16'h5000);
    load_program();
    run_and_check("mixed");

    // halt holds, then rerun from address 0
    budget += `CPU_DMEM_DEPTH + 40;
    repeat (20)
    begin
      @(negedge clk);
      check_halted("halt_hold", 1'b1, halted);
    end
    compare_memory("halt_hold");
    run = 1'b0;
    @(negedge clk);
    run_and_check("rerun");

    report_and_finish(1'b0);
  end

endmodule

// ==== cpu_top.sv ====
// top of the load/store core; ties the FSM, fetch unit, datapath and data memory to the host port
module cpu_top
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       run,
  input  logic       host_imem_we,
  input  logic       host_dmem_we,
  input  dmem_addr_t host_addr,
  input  word_t      host_wdata,
  output word_t      host_rdata,
  output logic       halted
);

  ctrl_t ctrl;
  word_t ir;
  word_t store_data;
  word_t mem_rdata;

  controller u_controller (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .ir     (ir),
    .ctrl   (ctrl),
    .halted (halted)
  );

  instruction_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .run        (run),
    .host_we    (host_imem_we),
    .host_addr  (host_addr[$bits(imem_addr_t)-1:0]),  // imem uses low bits
    .host_wdata (host_wdata),
    .ir         (ir)
  );

  datapath u_datapath (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .mem_rdata  (mem_rdata),
    .store_data (store_data)
  );

  data_memory u_dmem (
    .clk        (clk),
    .run        (run),
    .ctrl       (ctrl),
    .wdata      (store_data),
    .rdata      (mem_rdata),
    .host_we    (host_dmem_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

endmodule

// ==== data_memory.sv ====
// 256-word data memory; core port for load/store and host port for fill and readback
`include "cpu_settings.svh"

module data_memory
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       run,
  input  ctrl_t      ctrl,
  input  word_t      wdata,
  output word_t      rdata,
  input  logic       host_we,
  input  dmem_addr_t host_addr,
  input  word_t      host_wdata,
  output word_t      host_rdata
);

  word_t mem [`CPU_DMEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (ctrl.d_wr)
    begin
      mem[ctrl.d_addr] <= wdata;  // store
    end
    else if (!run && host_we)
    begin
      mem[host_addr] <= host_wdata;  // host fill, core stopped
    end
  end

  // both reads registered, one cycle
  always_ff @(posedge clk)
  begin
    rdata      <= mem[ctrl.d_addr];
    host_rdata <= mem[host_addr];
  end

endmodule

// ==== datapath.sv ====
// register file with two read ports, write-back select and add/subtract unit
`include "cpu_settings.svh"

module datapath
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  word_t mem_rdata,
  output word_t store_data
);

  word_t rf [`CPU_REG_COUNT];
  word_t ra_data;
  word_t rb_data;
  word_t alu_y;
  word_t wb_data;

  // combinational reads
  assign ra_data = rf[ctrl.ra_addr];
  assign rb_data = rf[ctrl.rb_addr];

  // wraps modulo 2^16
  always_comb
  begin
    if (ctrl.alu_sub)
    begin
      alu_y = ra_data - rb_data;
    end
    else
    begin
      alu_y = ra_data + rb_data;
    end
  end

  assign wb_data = ctrl.rf_s ? mem_rdata : alu_y;  // load vs alu result

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CPU_REG_COUNT; i++)
      begin
        rf[i] <= '0;
      end
    end
    else if (ctrl.w_wr)
    begin
      rf[ctrl.w_addr] <= wb_data;
    end
  end

  assign store_data = ra_data;  // port a feeds dmem write data

endmodule

// ==== instruction_fetch.sv ====
// instruction memory with host load port, program counter and instruction register
`include "cpu_settings.svh"

module instruction_fetch
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ctrl_t      ctrl,
  input  logic       run,
  input  logic       host_we,
  input  imem_addr_t host_addr,
  input  word_t      host_wdata,
  output word_t      ir
);

  word_t      imem [`CPU_IMEM_DEPTH];
  imem_addr_t pc;

  // program load only while the core is stopped
  always_ff @(posedge clk)
  begin
    if (!run && host_we)
    begin
      imem[host_addr] <= host_wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || ctrl.pc_clr)
    begin
      pc <= '0;
    end
    else if (ctrl.pc_up)
    begin
      pc <= pc + imem_addr_t'(1);  // wraps at 128
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.ir_ld)
    begin
      ir <= imem[pc];  // old pc, same edge as increment
    end
  end

endmodule

// ==== controller.sv ====
// multi-cycle FSM of the core; decodes the instruction register and drives every control field
module controller
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  run,
  input  word_t ir,
  output ctrl_t ctrl,
  output logic  halted
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  opcode_t     opcode;

  assign opcode = opcode_t'(ir[15:12]);
  assign halted = (state == S_HALT);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= S_INIT;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_INIT:   state_nxt = run ? S_FETCH : S_INIT;
      S_FETCH:  state_nxt = S_DECODE;
      S_DECODE:
      begin
        case (opcode)
          OP_STORE: state_nxt = S_STORE;
          OP_LOAD:  state_nxt = S_LOAD_A;
          OP_ADD:   state_nxt = S_ADD;
          OP_SUB:   state_nxt = S_SUB;
          OP_HALT:  state_nxt = S_HALT;
          default:  state_nxt = S_NOOP;  // NOOP and unknown codes
        endcase
      end
      S_LOAD_A: state_nxt = S_LOAD_B;
      S_NOOP,
      S_LOAD_B,
      S_STORE,
      S_ADD,
      S_SUB:    state_nxt = S_FETCH;
      S_HALT:   state_nxt = S_HALT;    // left only when run drops
      default:  state_nxt = S_INIT;
    endcase
    if (!run)
    begin
      state_nxt = S_INIT;
    end
  end

  always_comb
  begin
    ctrl = '0;

    // operand fields held steady from decode through execute
    if (state != S_INIT && state != S_FETCH && state != S_HALT)
    begin
      ctrl.d_addr  = ir[11:4];
      ctrl.w_addr  = ir[3:0];
      ctrl.rb_addr = ir[7:4];
      ctrl.ra_addr = (opcode == OP_STORE) ? ir[3:0] : ir[11:8];  // store source on port a
    end

    case (state)
      S_INIT:   ctrl.pc_clr = 1'b1;
      S_FETCH:
      begin
        ctrl.ir_ld = 1'b1;
        ctrl.pc_up = 1'b1;
      end
      S_STORE:  ctrl.d_wr = 1'b1;
      S_LOAD_B:
      begin
        ctrl.rf_s = 1'b1;  // take dmem rdata
        ctrl.w_wr = 1'b1;
      end
      S_ADD:    ctrl.w_wr = 1'b1;
      S_SUB:
      begin
        ctrl.alu_sub = 1'b1;
        ctrl.w_wr    = 1'b1;
      end
      default:  ctrl.w_wr = 1'b0;  // decode, noop, load_a, halt
    endcase
  end

endmodule

// ==== cpu_pkg.sv ====
// shared types of the load/store core: words, addresses, opcodes, FSM states, control bundle
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0]      word_t;       // data or instruction word
  typedef logic [`CPU_REG_ADDR_W-1:0]  reg_addr_t;   // register file index
  typedef logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr_t;  // data memory address
  typedef logic [`CPU_IMEM_ADDR_W-1:0] imem_addr_t;  // pc and imem address

  // top field of the instruction, ir[15:12]
  typedef enum logic [3:0] {
    OP_NOOP  = 4'd0,
    OP_STORE = 4'd1,  // reg -> dmem
    OP_LOAD  = 4'd2,  // dmem -> reg
    OP_ADD   = 4'd3,
    OP_SUB   = 4'd4,
    OP_HALT  = 4'd5
  } opcode_t;

  typedef enum logic [3:0] {
    S_INIT   = 4'd0,
    S_FETCH  = 4'd1,
    S_DECODE = 4'd2,
    S_NOOP   = 4'd3,
    S_LOAD_A = 4'd4,  // address to dmem
    S_LOAD_B = 4'd5,  // rdata to reg
    S_STORE  = 4'd6,
    S_ADD    = 4'd7,
    S_SUB    = 4'd8,
    S_HALT   = 4'd9
  } ctrl_state_t;

  typedef struct packed {
    logic       pc_clr;
    logic       pc_up;
    logic       ir_ld;
    dmem_addr_t d_addr;
    logic       d_wr;
    logic       rf_s;     // 1 = memory data to write-back
    reg_addr_t  w_addr;
    logic       w_wr;
    reg_addr_t  ra_addr;
    reg_addr_t  rb_addr;
    logic       alu_sub;  // 1 = ra - rb
  } ctrl_t;

endpackage

// ==== cpu_settings.svh ====
// width and depth defines for the load/store core, included by the package and memory blocks
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path word
`define CPU_DATA_W 16

// register file
`define CPU_REG_ADDR_W 4
`define CPU_REG_COUNT (1 << `CPU_REG_ADDR_W)

// data memory, 256 words
`define CPU_DMEM_ADDR_W 8
`define CPU_DMEM_DEPTH (1 << `CPU_DMEM_ADDR_W)

// instruction memory, 128 words
`define CPU_IMEM_ADDR_W 7
`define CPU_IMEM_DEPTH (1 << `CPU_IMEM_ADDR_W)

`endif
